//--- vlog.f
+incdir+.
lc3b_types.sv
control_rom.sv
regfile.sv
alu.sv
pipe_reg.sv
decode_stage.sv
execute_stage.sv
lc3b_core.sv
tb_clock.sv
tb_lc3b_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_lc3b_core -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_lc3b_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

//--- tb_lc3b_core.sv
`include "lc3b_defs.svh"

module tb_lc3b_core
    import lc3b_types::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // issued slots, reset, idle checks and per-test drain
    localparam int DIRECTED_SLOTS = 30;
    localparam int RANDOM_SLOTS   = 200;
    localparam int GAP_CYCLES     = 8 + 4 + 6 * 6;
    localparam int CYCLE_LIMIT    = DIRECTED_SLOTS + RANDOM_SLOTS + GAP_CYCLES + 50;

    typedef struct packed {
        logic     wr;
        lc3b_reg  dest;
        lc3b_word data;
        lc3b_nzp  nzp;
    } wb_expect_t;

    logic       clk;
    logic       arst_n;
    logic       instr_valid;
    lc3b_word   instr;
    lc3b_word   pc;
    logic       wb_valid;
    lc3b_reg    wb_dest;
    lc3b_word   wb_data;
    lc3b_nzp    cc;
    lc3b_word   model_regs [`LC3B_NREGS] = '{default: '0};
    wb_expect_t exp_q [$];
    wb_expect_t cur;
    lc3b_nzp    cc_due = 3'b010;   // z out of reset
    string      test_name = "reset";
    int         errors = 0;
    int         errors_at_start = 0;
    int         tests_run = 0;
    int         tests_bad = 0;
    int         cycles = 0;
    int         lat;
    integer     seed;

    tb_clock u_clock (.clk(clk), .arst_n(arst_n));

    lc3b_core DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_valid    (wb_valid),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data),
        .cc          (cc)
    );

    // applies the ISA rules to the model registers
    function automatic wb_expect_t model_exec(input lc3b_word ir, input lc3b_word ipc);
        wb_expect_t e;
        lc3b_word   a;
        lc3b_word   b;
        e      = '0;
        a      = model_regs[ir[8:6]];
        b      = ir[5] ? {{11{ir[4]}}, ir[4:0]} : model_regs[ir[2:0]];
        e.dest = ir[11:9];
        e.wr   = 1'b1;
        case (ir[15:12])
            4'b0001: e.data = a + b;
            4'b0101: e.data = a & b;
            4'b1001: e.data = ~a;
            4'b1101: begin
                if (!ir[4]) begin
                    e.data = a << ir[3:0];
                end else if (!ir[5]) begin
                    e.data = a >> ir[3:0];
                end else begin
                    e.data = lc3b_word'($signed(a) >>> ir[3:0]);
                end
            end
            4'b1110: e.data = ipc + 16'd2 + {{6{ir[8]}}, ir[8:0], 1'b0};
            default: e.wr = 1'b0;   // no writeback and no cc change
        endcase
        if (e.wr) begin
            model_regs[e.dest] = e.data;
            e.nzp = e.data[15] ? 3'b100 : (e.data == '0 ? 3'b010 : 3'b001);
        end
        return e;
    endfunction

    function automatic lc3b_word alu_imm(input logic [3:0] op, input lc3b_reg dr,
                                         input lc3b_reg sr, input logic [4:0] imm);
        return {op, dr, sr, 1'b1, imm};
    endfunction

    function automatic lc3b_word alu_reg(input logic [3:0] op, input lc3b_reg dr,
                                         input lc3b_reg sa, input lc3b_reg sb);
        return {op, dr, sa, 3'b000, sb};
    endfunction

    task automatic issue(input lc3b_word ir, input lc3b_word ipc);
        wb_expect_t e;
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = ir;
        pc          = ipc;
        e = model_exec(ir, ipc);
        if (e.wr) begin
            exp_q.push_back(e);
        end
    endtask

    task automatic idle();
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = '0;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        idle();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(negedge clk);   // lets the trailing cc check land
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%-11s : ok", test_name);
        end else begin
            tests_bad++;
            $display("%-11s : %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic random_stream(input int n);
        logic [31:0] r;
        logic [31:0] w;
        logic [3:0]  op;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            w = $random(seed);
            if (r[1:0] == 2'd0) begin
                idle();
            end else if (r[1:0] == 2'd1) begin
                issue(w[15:0], w[31:16]);   // any opcode, mostly excluded ones
            end else begin
                case (r[4:2])
                    3'd0, 3'd5: op = op_add;
                    3'd1, 3'd6: op = op_and;
                    3'd2:       op = op_not;
                    3'd3, 3'd7: op = op_shf;
                    default:    op = op_lea;
                endcase
                issue({op, w[11:0]}, w[31:16]);
            end
        end
    endtask

    // compare at the falling edge, where the registered outputs are settled
    always @(negedge clk) begin
        if (arst_n) begin
            assert (cc == cc_due) else begin
                $display("[ERROR] %s: cc expected %b, actual %b", test_name, cc_due, cc);
                errors++;
            end
        end
        if (arst_n && wb_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("%s: writeback to r%0d with no instruction outstanding",
                         test_name, wb_dest);
                errors++;
            end
            if (exp_q.size() != 0) begin
                cur = exp_q.pop_front();
                assert (wb_dest == cur.dest) else begin
                    $display("[ERROR] %s: wb_dest expected %0d, actual %0d",
                             test_name, cur.dest, wb_dest);
                    errors++;
                end
                assert (wb_data == cur.data) else begin
                    $display("[ERROR] %s: wb_data expected %h, actual %h",
                             test_name, cur.data, wb_data);
                    errors++;
                end
                cc_due = cur.nzp;   // cc follows on the next edge
            end
        end
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= CYCLE_LIMIT);
        $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        seed        = 32'hee63;
        wait (arst_n === 1'b1);

        start_test("reset_idle");
        repeat (4) begin
            @(negedge clk);
            assert (!wb_valid && cc == 3'b010) else begin
                $display("[ERROR] %s: wb_valid,cc expected 0,010, actual %b,%b",
                         test_name, wb_valid, cc);
                errors++;
            end
        end
        issue(alu_imm(op_add, 3'd1, 3'd0, 5'd3), 16'h3000);
        lat = 0;
        do begin
            idle();
            lat++;
            assert (cc == 3'b010) else begin
                $display("[ERROR] %s: cc expected 010, actual %b", test_name, cc);
                errors++;
            end
        end while (!wb_valid && lat < 8);
        assert (lat == `LC3B_WB_LATENCY) else begin
            $display("[ERROR] %s: latency expected %0d, actual %0d",
                     test_name, `LC3B_WB_LATENCY, lat);
            errors++;
        end
        finish_test();

        start_test("imm_build");
        issue(alu_imm(op_add, 3'd1, 3'd1, 5'd5), 16'h3000);
        issue(alu_imm(op_add, 3'd2, 3'd0, 5'h1d), 16'h3002);   // -3
        issue(alu_imm(op_and, 3'd3, 3'd2, 5'h0c), 16'h3004);
        issue(alu_imm(op_and, 3'd4, 3'd0, 5'h1f), 16'h3006);
        issue(alu_imm(op_add, 3'd1, 3'd1, 5'h0f), 16'h3008);
        issue(alu_imm(op_add, 3'd5, 3'd2, 5'h10), 16'h300a);   // -16
        finish_test();

        start_test("fwd_bypass");
        issue(alu_imm(op_add, 3'd1, 3'd0, 5'd9), 16'h3100);
        issue(alu_reg(op_add, 3'd2, 3'd1, 3'd1), 16'h3102);
        issue(alu_reg(op_add, 3'd3, 3'd2, 3'd1), 16'h3104);
        issue(alu_reg(op_and, 3'd4, 3'd3, 3'd2), 16'h3106);
        idle();
        issue(alu_reg(op_add, 3'd5, 3'd4, 3'd3), 16'h310a);   // r4 via regfile bypass
        issue(alu_reg(op_add, 3'd6, 3'd5, 3'd5), 16'h310c);
        issue(alu_reg(op_and, 3'd7, 3'd6, 3'd5), 16'h310e);
        issue(alu_reg(op_add, 3'd1, 3'd1, 3'd1), 16'h3110);
        issue(alu_reg(op_add, 3'd1, 3'd1, 3'd1), 16'h3112);
        finish_test();

        start_test("not_shift");
        issue(alu_imm(op_add, 3'd1, 3'd0, 5'h18), 16'h3200);   // -8
        issue({op_not, 3'd2, 3'd1, 6'h3f}, 16'h3202);
        issue({op_shf, 3'd3, 3'd2, 2'b00, 4'd4}, 16'h3204);    // sll
        issue({op_shf, 3'd4, 3'd1, 2'b01, 4'd4}, 16'h3206);    // srl
        issue({op_shf, 3'd5, 3'd1, 2'b11, 4'd2}, 16'h3208);    // sra of a negative
        issue({op_shf, 3'd6, 3'd3, 2'b11, 4'd15}, 16'h320a);
        issue({op_shf, 3'd7, 3'd1, 2'b00, 4'd15}, 16'h320c);
        issue({op_not, 3'd0, 3'd0, 6'h3f}, 16'h320e);
        finish_test();

        start_test("lea_offsets");
        issue({op_lea, 3'd1, 9'h005}, 16'h3000);
        issue({op_lea, 3'd2, 9'h1ff}, 16'h4000);
        issue({op_lea, 3'd3, 9'h100}, 16'h0100);
        issue({op_lea, 3'd4, 9'h000}, 16'hfffe);
        issue({op_lea, 3'd5, 9'h0ff}, 16'h8000);
        finish_test();

        start_test("random_mix");
        random_stream(RANDOM_SLOTS);
        finish_test();

        $display("summary: %0d tests, %0d clean, %0d with errors, %0d errors in all",
                 tests_run, tests_run - tests_bad, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tb_lc3b_core

//--- tb_clock.sv
module tb_clock (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);   // release away from the active edge
        arst_n = 1'b1;
    end

endmodule : tb_clock

//--- lc3b_core.sv
module lc3b_core
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     instr_valid,
    input  lc3b_word instr,
    input  lc3b_word pc,
    output logic     wb_valid,
    output lc3b_reg  wb_dest,
    output lc3b_word wb_data,
    output lc3b_nzp  cc
);

    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_wb_t  ex_wb_d;
    ex_wb_t  wb_q;        // writeback bus
    lc3b_nzp cc_next;

    decode_stage u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb          (wb_q),
        .id_ex       (id_ex_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .d      (id_ex_d),
        .q      (id_ex_q)
    );

    execute_stage u_execute (
        .id_ex (id_ex_q),
        .wb    (wb_q),
        .ex_wb (ex_wb_d)
    );

    pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .d      (ex_wb_d),
        .q      (wb_q)
    );

    assign wb_valid = wb_q.valid && wb_q.regfile_load;
    assign wb_dest  = wb_q.dest;
    assign wb_data  = wb_q.result;

    always_comb begin
        if (wb_q.result[15]) begin
            cc_next = 3'b100;   // negative
        end else if (wb_q.result == '0) begin
            cc_next = 3'b010;
        end else begin
            cc_next = 3'b001;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cc <= 3'b010;   // z out of reset
        end else if (wb_q.valid && wb_q.cc_load) begin
            cc <= cc_next;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) $onehot(cc))
        else $error("lc3b_core: cc not one-hot (%b)", cc);

endmodule : lc3b_core

//--- execute_stage.sv
module execute_stage
    import lc3b_types::*;
(
    input  id_ex_t id_ex,
    input  ex_wb_t wb,
    output ex_wb_t ex_wb
);

    logic     wb_writes;
    lc3b_word sr1_val;
    lc3b_word sr2_val;
    lc3b_word alu_b;
    lc3b_word alu_f;
    lc3b_word pc_sum;
    logic     use_pcn;

    // bypass from the instruction one ahead
    assign wb_writes = wb.valid && wb.regfile_load;
    assign sr1_val   = (wb_writes && (wb.dest == id_ex.sr1)) ? wb.result : id_ex.sr1_data;
    assign sr2_val   = (wb_writes && (wb.dest == id_ex.sr2)) ? wb.result : id_ex.sr2_data;

    always_comb begin
        case (id_ex.ctrl.alu_mux_sel)
            lc3b_alu_mux_sel_imm5: alu_b = id_ex.imm5;
            lc3b_alu_mux_sel_imm4: alu_b = id_ex.imm4;
            default:               alu_b = sr2_val;
        endcase
    end

    alu u_alu (
        .aluop (id_ex.ctrl.alu_op),
        .a     (sr1_val),
        .b     (alu_b),
        .f     (alu_f)
    );

    // pc + 2 + word offset
    assign pc_sum = id_ex.pc + lc3b_word'(2) + {id_ex.offset9[14:0], 1'b0};

    // lea takes the pc sum
    assign use_pcn = (id_ex.ctrl.regfile_data_mux_sel == lc3b_regfile_data_mux_sel_pcn);

    always_comb begin
        ex_wb.valid        = id_ex.valid;
        ex_wb.regfile_load = id_ex.ctrl.regfile_load;
        ex_wb.cc_load      = id_ex.ctrl.cc_load;
        ex_wb.dest         = id_ex.dest;
        ex_wb.result       = use_pcn ? pc_sum : alu_f;
    end

    // a writing alu-sourced op must carry a real alu operation
    always_comb begin
        assert (!(id_ex.valid && id_ex.ctrl.regfile_load
                  && id_ex.ctrl.regfile_data_mux_sel == lc3b_regfile_data_mux_sel_alu
                  && id_ex.ctrl.alu_op == lc3b_alu_op_pass))
            else $error("execute_stage: pass op would write sr1 back to r%0d", id_ex.dest);
    end

endmodule : execute_stage

//--- decode_stage.sv
`include "lc3b_defs.svh"

module decode_stage
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     instr_valid,
    input  lc3b_word instr,
    input  lc3b_word pc,
    input  ex_wb_t   wb,
    output id_ex_t   id_ex
);

    lc3b_control_word ctrl;
    lc3b_reg          dest;
    lc3b_reg          sr1;
    lc3b_reg          sr2;
    lc3b_word         sr1_data;
    lc3b_word         sr2_data;

    assign dest = instr[11:9];
    assign sr1  = instr[8:6];
    assign sr2  = instr[2:0];   // overlaps imm5 in the immediate forms

    control_rom u_control_rom (
        .ir_in       (instr),
        .control_out (ctrl)
    );

    regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (wb.valid && wb.regfile_load),
        .dest    (wb.dest),
        .in      (wb.result),
        .sr1     (sr1),
        .sr2     (sr2),
        .sr1_out (sr1_data),
        .sr2_out (sr2_data)
    );

    always_comb begin
        id_ex.valid    = instr_valid;
        id_ex.ctrl     = instr_valid ? ctrl : '0;   // idle cycle is a bubble
        id_ex.pc       = pc;
        id_ex.dest     = dest;
        id_ex.sr1      = sr1;
        id_ex.sr2      = sr2;
        id_ex.sr1_data = sr1_data;
        id_ex.sr2_data = sr2_data;
        id_ex.imm5     = {{(`LC3B_WORD_W - 5){instr[4]}}, instr[4:0]};
        id_ex.imm4     = {{(`LC3B_WORD_W - 4){instr[3]}}, instr[3:0]};
        id_ex.offset9  = {{(`LC3B_WORD_W - 9){instr[8]}}, instr[8:0]};
    end

endmodule : decode_stage

//--- pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  payload_t d,
    output payload_t q
);

    // captures every clock, no enable
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule : pipe_reg

//--- alu.sv
module alu
    import lc3b_types::*;
(
    input  lc3b_alu_op aluop,
    input  lc3b_word   a,
    input  lc3b_word   b,
    output lc3b_word   f
);

    logic [3:0] shamt;

    assign shamt = b[3:0];   // shifts use the low nibble only

    always_comb begin
        case (aluop)
            lc3b_alu_op_add: f = a + b;
            lc3b_alu_op_and: f = a & b;
            lc3b_alu_op_not: f = ~a;
            lc3b_alu_op_sll: f = a << shamt;
            lc3b_alu_op_srl: f = a >> shamt;
            lc3b_alu_op_sra: f = lc3b_word'($signed(a) >>> shamt);  // keeps sign
            default:         f = a;   // pass
        endcase
    end

endmodule : alu

//--- regfile.sv
`include "lc3b_defs.svh"

module regfile
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load,
    input  lc3b_reg  dest,
    input  lc3b_word in,
    input  lc3b_reg  sr1,
    input  lc3b_reg  sr2,
    output lc3b_word sr1_out,
    output lc3b_word sr2_out
);

    lc3b_word data [`LC3B_NREGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LC3B_NREGS; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[dest] <= in;
        end
    end

    // write-first, so decode sees a value retiring this cycle
    always_comb begin
        sr1_out = (load && (dest == sr1)) ? in : data[sr1];
        sr2_out = (load && (dest == sr2)) ? in : data[sr2];
    end

endmodule : regfile

//--- control_rom.sv
module control_rom
    import lc3b_types::*;
(
    input  lc3b_word         ir_in,
    output lc3b_control_word control_out
);

    lc3b_opcode opcode;

    assign opcode = lc3b_opcode'(ir_in[15:12]);

    always_comb begin
        control_out.alu_op               = lc3b_alu_op_pass;
        control_out.alu_mux_sel          = lc3b_alu_mux_sel_sr2;
        control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_alu;
        control_out.cc_gen_mux_sel       = lc3b_cc_gen_mux_sel_alu;
        control_out.cc_load              = 1'b0;
        control_out.regfile_load         = 1'b0;

        case (opcode)
            op_add: begin
                if (ir_in[5]) begin
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_imm5;   // immediate form
                end else begin
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_sr2;
                end
                control_out.alu_op               = lc3b_alu_op_add;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_alu;
                control_out.cc_gen_mux_sel       = lc3b_cc_gen_mux_sel_alu;
                control_out.cc_load              = 1'b1;
                control_out.regfile_load         = 1'b1;
            end

            op_and: begin
                if (ir_in[5]) begin
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_imm5;
                end else begin
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_sr2;
                end
                control_out.alu_op               = lc3b_alu_op_and;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_alu;
                control_out.cc_gen_mux_sel       = lc3b_cc_gen_mux_sel_alu;
                control_out.cc_load              = 1'b1;
                control_out.regfile_load         = 1'b1;
            end

            op_not: begin
                control_out.alu_op               = lc3b_alu_op_not;   // operand b ignored
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_alu;
                control_out.cc_gen_mux_sel       = lc3b_cc_gen_mux_sel_alu;
                control_out.cc_load              = 1'b1;
                control_out.regfile_load         = 1'b1;
            end

            op_shf: begin
                control_out.alu_mux_sel = lc3b_alu_mux_sel_imm4;
                // bit 4 picks left/right, bit 5 picks logical/arithmetic
                if (!ir_in[4]) begin
                    control_out.alu_op = lc3b_alu_op_sll;
                end else if (!ir_in[5]) begin
                    control_out.alu_op = lc3b_alu_op_srl;
                end else begin
                    control_out.alu_op = lc3b_alu_op_sra;
                end
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_alu;
                control_out.cc_gen_mux_sel       = lc3b_cc_gen_mux_sel_alu;
                control_out.cc_load              = 1'b1;
                control_out.regfile_load         = 1'b1;
            end

            op_lea: begin
                control_out.alu_op               = lc3b_alu_op_pass;  // alu unused
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_pcn;
                control_out.cc_gen_mux_sel       = lc3b_cc_gen_mux_sel_pcn;
                control_out.cc_load              = 1'b1;
                control_out.regfile_load         = 1'b1;
            end

            default: begin
                control_out = '0;   // memory, branch and trap ops become bubbles
            end
        endcase
    end

    // condition codes only ever move together with a register write
    always_comb begin
        assert (!(control_out.cc_load && !control_out.regfile_load))
            else $error("control_rom: cc_load without regfile_load, opcode %b", ir_in[15:12]);
    end

endmodule : control_rom

//--- lc3b_types.sv
`include "lc3b_defs.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [$clog2(`LC3B_NREGS)-1:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;              // n, z, p

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // pass sits at zero so a cleared control word is a no-op
    typedef enum logic [2:0] {
        lc3b_alu_op_pass,
        lc3b_alu_op_add,
        lc3b_alu_op_and,
        lc3b_alu_op_not,
        lc3b_alu_op_sll,
        lc3b_alu_op_srl,
        lc3b_alu_op_sra
    } lc3b_alu_op;

    typedef enum logic [1:0] {
        lc3b_alu_mux_sel_sr2,
        lc3b_alu_mux_sel_imm5,
        lc3b_alu_mux_sel_imm4
    } lc3b_alu_mux_sel;

    typedef enum logic {
        lc3b_regfile_data_mux_sel_alu,
        lc3b_regfile_data_mux_sel_pcn
    } lc3b_regfile_data_mux_sel;

    typedef enum logic {
        lc3b_cc_gen_mux_sel_alu,
        lc3b_cc_gen_mux_sel_pcn
    } lc3b_cc_gen_mux_sel;

    typedef struct packed {
        lc3b_alu_op               alu_op;
        lc3b_alu_mux_sel          alu_mux_sel;
        lc3b_regfile_data_mux_sel regfile_data_mux_sel;
        lc3b_cc_gen_mux_sel       cc_gen_mux_sel;
        logic                     cc_load;
        logic                     regfile_load;
    } lc3b_control_word;

    typedef struct packed {
        logic             valid;
        lc3b_control_word ctrl;
        lc3b_word         pc;
        lc3b_reg          dest;
        lc3b_reg          sr1;
        lc3b_reg          sr2;
        lc3b_word         sr1_data;
        lc3b_word         sr2_data;
        lc3b_word         imm5;      // sign-extended
        lc3b_word         imm4;
        lc3b_word         offset9;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        logic     regfile_load;
        logic     cc_load;
        lc3b_reg  dest;
        lc3b_word result;
    } ex_wb_t;

endpackage : lc3b_types

//--- lc3b_defs.svh
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// datapath and instruction width
`define LC3B_WORD_W 16

// architectural registers R0..R7
`define LC3B_NREGS 8

// clocks from the issue cycle to the writeback cycle
`define LC3B_WB_LATENCY 2

`endif
